/* Makefile */
VERILATOR  ?= verilator
TOP        := scr_ram_tb
FILELIST   := sources.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/scr_ram_cases.txt */
// Columns: op_addr_wdata_be_expected in hex, op 1 write, 2 read, 3 idle, 0 end
// Expected data counts for reads only, operations run back to back
1_10_11223344_f_00000000
3_00_00000000_0_00000000
2_10_00000000_0_11223344
1_10_aabbccdd_5_00000000
2_10_00000000_0_11bb33dd
1_20_cafef00d_f_00000000
2_20_00000000_0_cafef00d
1_20_12345678_c_00000000
3_00_00000000_0_00000000
2_20_00000000_0_1234f00d
1_30_01020304_f_00000000
2_30_00000000_0_01020304
1_30_a0b0c0d0_2_00000000
2_30_00000000_0_0102c004
3_00_00000000_0_00000000
2_30_00000000_0_0102c004
1_40_deadbeef_f_00000000
2_10_00000000_0_11bb33dd
1_40_00ff0000_4_00000000
2_40_00000000_0_deffbeef
3_00_00000000_0_00000000
2_40_00000000_0_deffbeef

/* bench/scr_ram_tb.sv */
// Testbench for the scrambled RAM with cases replay, random traffic, key gating and init fill
`include "scr_ram_defs.svh"

module scr_ram_tb;

  import scr_ram_pkg::*;

  localparam int GrantLimit = 16;
  localparam int InitLimit  = 300;
  localparam int MaxCases   = 64;
  localparam int RandomOps  = 400;

  logic   clk_i = 1'b0;
  logic   rst_ni;
  logic   key_valid_i;
  key_t   key_i;
  block_t nonce_i;
  lfsr_t  init_seed_i;
  logic   init_req_i;
  logic   init_ack_o;
  logic   req_i;
  logic   gnt_o;
  logic   write_i;
  addr_t  addr_i;
  data_t  wdata_i;
  be_t    be_i;
  data_t  rdata_o;
  logic   rvalid_o;

  // Shadow copy of the memory as the bus sees it
  data_t       shadow [`SCR_DEPTH];
  // One row per operation, op then address, write data, byte enables and expected data
  logic [79:0] cases_mem [MaxCases];
  logic [31:0] rng_state;
  int unsigned mismatches;
  int unsigned failures;
  logic        abort;
  // Read granted last cycle and the word it has to return
  logic        rd_pend;
  data_t       rd_exp;
  addr_t       rd_addr;

  scr_ram_top u_dut (
    .clk_i,
    .rst_ni,
    .key_valid_i,
    .key_i,
    .nonce_i,
    .init_seed_i,
    .init_req_i,
    .init_ack_o,
    .req_i,
    .gnt_o,
    .write_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .rdata_o,
    .rvalid_o
  );

  always #10 clk_i = ~clk_i;

  ////////////////////
  // Model helpers
  ////////////////////

  function automatic logic [31:0] next_random(logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Left shift with the parity of the tapped bits coming in at the bottom
  function automatic lfsr_t lfsr_step(lfsr_t s);
    return {s[`SCR_LFSR_W-2:0], ^(s & lfsr_t'(`SCR_LFSR_TAPS))};
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t m;
    m = old_word;
    for (int b = 0; b < `SCR_BYTES; b++) begin
      if (be[b]) begin
        m[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return m;
  endfunction

  ////////////////////
  // Bus tasks
  ////////////////////

  // Called once per cycle at the falling edge, when the outputs have settled
  task automatic check_outputs();
    assert (rvalid_o == rd_pend) else begin
      mismatches++;
      $display("Mismatch rvalid_o: got %h expected %h", rvalid_o, rd_pend);
    end
    if (rd_pend) begin
      assert (rdata_o == rd_exp) else begin
        mismatches++;
        $display("Mismatch rdata_o at %h: got %h expected %h", rd_addr, rdata_o, rd_exp);
      end
    end else begin
      assert (rdata_o == '0) else begin
        mismatches++;
        $display("Mismatch rdata_o while idle: got %h expected %h", rdata_o, 32'h0);
      end
    end
    rd_pend = 1'b0;
  endtask

  // Holds the request until it is granted, the next access follows right after
  task automatic drive_access(input logic wr, input addr_t a, input data_t d, input be_t b,
                              input data_t exp_data);
    int tries;
    if (abort) return;
    tries = 0;
    @(posedge clk_i);
    req_i   <= 1'b1;
    write_i <= wr;
    addr_i  <= a;
    wdata_i <= d;
    be_i    <= b;
    @(negedge clk_i);
    check_outputs();
    while (!gnt_o && tries < GrantLimit) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_outputs();
      tries++;
    end
    if (!gnt_o) begin
      failures++;
      abort = 1'b1;
      $display("Request to address %h was never granted", a);
      return;
    end
    if (wr) begin
      shadow[a] = merge_bytes(shadow[a], d, b);
    end else begin
      rd_pend = 1'b1;
      rd_exp  = exp_data;
      rd_addr = a;
    end
  endtask

  task automatic idle_cycles(input int n);
    if (abort) return;
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      req_i   <= 1'b0;
      write_i <= 1'b0;
      @(negedge clk_i);
      check_outputs();
    end
  endtask

  task automatic read_back_all();
    for (int n = 0; n < `SCR_DEPTH; n++) begin
      drive_access(1'b0, addr_t'(n), '0, '0, shadow[n]);
    end
    idle_cycles(2);
  endtask

  ////////////////////
  // Test phases
  ////////////////////

  // A read waits on the bus during the fill and must never be granted
  task automatic run_init(input lfsr_t seed);
    int    k;
    logic  acked;
    lfsr_t st;
    if (abort) return;
    @(posedge clk_i);
    init_req_i  <= 1'b1;
    init_seed_i <= seed;
    req_i       <= 1'b0;
    @(negedge clk_i);
    check_outputs();
    k     = 0;
    acked = 1'b0;
    while (!acked && k < InitLimit) begin
      @(posedge clk_i);
      req_i   <= 1'b1;
      write_i <= 1'b0;
      addr_i  <= addr_t'(k);
      k++;
      @(negedge clk_i);
      check_outputs();
      assert (gnt_o == 1'b0) else begin
        mismatches++;
        $display("Mismatch gnt_o during fill: got %h expected %h", gnt_o, 1'b0);
      end
      acked = init_ack_o;
    end
    if (!acked) begin
      failures++;
      abort = 1'b1;
      $display("Init acknowledge never arrived");
      return;
    end
    assert (k == `SCR_DEPTH) else begin
      mismatches++;
      $display("Mismatch init_ack_o cycle: got %h expected %h", k, `SCR_DEPTH);
    end
    @(posedge clk_i);
    init_req_i <= 1'b0;
    req_i      <= 1'b0;
    @(negedge clk_i);
    check_outputs();
    // Word n holds the LFSR state after n steps in every byte
    st = seed;
    for (int n = 0; n < `SCR_DEPTH; n++) begin
      shadow[n] = {`SCR_BYTES{st}};
      st = lfsr_step(st);
    end
  endtask

  task automatic replay_cases();
    logic [79:0] row;
    logic [3:0]  op;
    for (int i = 0; i < MaxCases; i++) begin
      row = cases_mem[i];
      op  = row[79:76];
      if (op == 4'h0) break;
      case (op)
        4'h1:    drive_access(1'b1, row[75:68], row[67:36], row[35:32], '0);
        4'h2:    drive_access(1'b0, row[75:68], '0, '0, row[31:0]);
        default: idle_cycles(1);
      endcase
    end
    idle_cycles(2);
  endtask

  task automatic random_traffic();
    addr_t a;
    data_t d;
    be_t   b;
    logic [1:0] kind;
    for (int i = 0; i < RandomOps; i++) begin
      rng_state = next_random(rng_state);
      // Half the accesses stay in 16 words so that collisions are frequent
      a    = rng_state[8] ? rng_state[7:0] : {4'h0, rng_state[3:0]};
      b    = rng_state[12] ? 4'hf : rng_state[19:16];
      kind = rng_state[21:20];
      rng_state = next_random(rng_state);
      d = rng_state;
      if (kind == 2'd0) begin
        idle_cycles(1);
      end else if (kind == 2'd1) begin
        drive_access(1'b0, a, '0, '0, shadow[a]);
      end else begin
        drive_access(1'b1, a, d, b, '0);
      end
    end
    idle_cycles(2);
  endtask

  // Without a valid key nothing is granted and memory stays as it was
  task automatic key_gating();
    if (abort) return;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_i);
      key_valid_i <= 1'b0;
      req_i       <= 1'b1;
      write_i     <= i[0];
      addr_i      <= addr_t'(i * 16);
      wdata_i     <= 32'hffff_ffff;
      be_i        <= 4'hf;
      @(negedge clk_i);
      check_outputs();
      assert (gnt_o == 1'b0) else begin
        mismatches++;
        $display("Mismatch gnt_o without key: got %h expected %h", gnt_o, 1'b0);
      end
    end
    @(posedge clk_i);
    req_i       <= 1'b0;
    key_valid_i <= 1'b1;
    @(negedge clk_i);
    check_outputs();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    mismatches  = 0;
    failures    = 0;
    abort       = 1'b0;
    rd_pend     = 1'b0;
    rd_exp      = '0;
    rd_addr     = '0;
    rng_state   = 32'd82;
    rst_ni      = 1'b0;
    key_valid_i = 1'b1;
    key_i       = 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0;
    nonce_i     = 64'h5a13c4e29b7d0f61;
    init_seed_i = '0;
    init_req_i  = 1'b0;
    req_i       = 1'b0;
    write_i     = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    be_i        = '0;
    for (int i = 0; i < MaxCases; i++) begin
      cases_mem[i] = '0;
    end
    for (int n = 0; n < `SCR_DEPTH; n++) begin
      shadow[n] = '0;
    end
    $readmemh("bench/scr_ram_cases.txt", cases_mem);

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    assert (gnt_o == 1'b0) else begin
      mismatches++;
      $display("Mismatch gnt_o in reset: got %h expected %h", gnt_o, 1'b0);
    end
    assert (rvalid_o == 1'b0) else begin
      mismatches++;
      $display("Mismatch rvalid_o in reset: got %h expected %h", rvalid_o, 1'b0);
    end
    assert (init_ack_o == 1'b0) else begin
      mismatches++;
      $display("Mismatch init_ack_o in reset: got %h expected %h", init_ack_o, 1'b0);
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // Fill first so that every word has a known value
    run_init(8'h5b);
    read_back_all();
    replay_cases();
    random_traffic();
    key_gating();
    read_back_all();
    run_init(8'hc3);
    read_back_all();

    $display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0 && !abort) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* common/scr_ram_defs.svh */
// Depth, width, round count and LFSR macros for the scrambled RAM
`ifndef SCR_RAM_DEFS_SVH
`define SCR_RAM_DEFS_SVH

////////////////////
// Memory geometry
////////////////////

// Number of words in the memory macro
`define SCR_DEPTH 256
// Word address width, log2 of the depth
`define SCR_ADDR_W 8
// Bus data width and its byte lanes
`define SCR_DATA_W 32
`define SCR_BYTES 4

////////////////////
// Cipher setup
////////////////////

// One PRINCE style block and its key
`define SCR_BLOCK_W 64
`define SCR_KEY_W 128
// Half rounds on each side of the halfway register
`define SCR_CIPHER_HALF_ROUNDS 2
// Substitution/permutation rounds inside each byte
`define SCR_DIFF_ROUNDS 2
// Substitution/permutation rounds on the row address
`define SCR_ADDR_ROUNDS 2

////////////////////
// Init LFSR
////////////////////

// Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
`define SCR_LFSR_W 8
`define SCR_LFSR_TAPS 8'hB8

`endif

/* common/scr_ram_pkg.sv */
// Scrambled RAM types, nonce union, S-box and bit interleave functions
`include "scr_ram_defs.svh"

package scr_ram_pkg;

  typedef logic [`SCR_ADDR_W-1:0]  addr_t;
  typedef logic [`SCR_DATA_W-1:0]  data_t;
  typedef logic [`SCR_BYTES-1:0]   be_t;
  typedef logic [`SCR_KEY_W-1:0]   key_t;
  typedef logic [`SCR_BLOCK_W-1:0] block_t;
  typedef logic [`SCR_LFSR_W-1:0]  lfsr_t;

  // Upper nonce bits key the address map, the rest seed the counter block
  typedef struct packed {
    logic [`SCR_ADDR_W-1:0]               addr_key;
    logic [`SCR_BLOCK_W-`SCR_ADDR_W-1:0] data_nonce;
  } nonce_s;

  typedef union packed {
    block_t raw;
    nonce_s fields;
  } nonce_u;

  // PRINCE S-box, entry 0 sits in the lowest nibble
  localparam logic [15:0][3:0] SBOX4     = 64'h4D5E087619CA23FB;
  localparam logic [15:0][3:0] SBOX4_INV = 64'h1CE5046A98DF237B;

  function automatic logic [3:0] sbox4(logic [3:0] d);
    return SBOX4[d];
  endfunction

  function automatic logic [3:0] sbox4_inv(logic [3:0] d);
    return SBOX4_INV[d];
  endfunction

  // Even bits gather in the lower half and odd bits in the upper half
  // Only the lowest w bits take part, w must be even
  function automatic block_t perm_bits(block_t d, int unsigned w);
    block_t o;
    o = '0;
    for (int unsigned i = 0; i < w / 2; i++) begin
      o[i]         = d[2*i];
      o[w/2 + i]   = d[2*i + 1];
    end
    return o;
  endfunction

  // Undo the interleave, lower half back to even and upper half to odd bits
  function automatic block_t perm_bits_inv(block_t d, int unsigned w);
    block_t o;
    o = '0;
    for (int unsigned i = 0; i < w / 2; i++) begin
      o[2*i]     = d[i];
      o[2*i + 1] = d[w/2 + i];
    end
    return o;
  endfunction

endpackage

/* rtl/addr_scrambler.sv */
// Keyed bijective substitution/permutation network on the row address
`include "scr_ram_defs.svh"

module addr_scrambler (
  input  scr_ram_pkg::addr_t addr_i,
  input  scr_ram_pkg::addr_t key_i,
  output scr_ram_pkg::addr_t addr_o
);

  import scr_ram_pkg::*;

  addr_t  a;
  block_t p;

  // Key XOR, nibble S-boxes and interleave are each invertible,
  // so every logical word lands on its own row
  always_comb begin
    a = addr_i;
    for (int r = 0; r < `SCR_ADDR_ROUNDS; r++) begin
      a = a ^ key_i;
      for (int n = 0; n < `SCR_ADDR_W / 4; n++) begin
        a[4*n +: 4] = sbox4(a[4*n +: 4]);
      end
      p = perm_bits(block_t'(a), `SCR_ADDR_W);
      a = p[`SCR_ADDR_W-1:0];
    end
    addr_o = a;
  end

endmodule

/* rtl/sram_1p.sv */
// Behavioral single-port SRAM with byte enables and one-cycle read latency
`include "scr_ram_defs.svh"

module sram_1p (
  input  logic               clk_i,
  input  logic               req_i,
  input  logic               write_i,
  input  scr_ram_pkg::addr_t addr_i,
  input  scr_ram_pkg::data_t wdata_i,
  input  scr_ram_pkg::be_t   be_i,
  output scr_ram_pkg::data_t rdata_o
);

  import scr_ram_pkg::*;

  localparam int ByteW = `SCR_DATA_W / `SCR_BYTES;

  data_t mem [`SCR_DEPTH];

  // Read data shows up the cycle after the request and holds across writes
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        for (int b = 0; b < `SCR_BYTES; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*ByteW +: ByteW] <= wdata_i[b*ByteW +: ByteW];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* scr_ram/data_scrambler.sv */
// Write path keystream XOR plus byte diffusion, read path inverse diffusion plus XOR
`include "scr_ram_defs.svh"

module data_scrambler (
  input  scr_ram_pkg::data_t wdata_i,
  input  scr_ram_pkg::data_t rdata_scr_i,
  input  scr_ram_pkg::data_t keystream_i,
  output scr_ram_pkg::data_t wdata_scr_o,
  output scr_ram_pkg::data_t rdata_plain_o
);

  import scr_ram_pkg::*;

  localparam int ByteW = `SCR_DATA_W / `SCR_BYTES;

  // Diffusion stays inside a byte so that byte enables keep working
  function automatic logic [ByteW-1:0] diffuse(logic [ByteW-1:0] d);
    logic [ByteW-1:0] s;
    block_t           p;
    s = d;
    for (int r = 0; r < `SCR_DIFF_ROUNDS; r++) begin
      for (int n = 0; n < ByteW / 4; n++) begin
        s[4*n +: 4] = sbox4(s[4*n +: 4]);
      end
      p = perm_bits(block_t'(s), ByteW);
      s = p[ByteW-1:0];
    end
    return s;
  endfunction

  // Same rounds run backwards with the inverse layers
  function automatic logic [ByteW-1:0] undiffuse(logic [ByteW-1:0] d);
    logic [ByteW-1:0] s;
    block_t           p;
    s = d;
    for (int r = 0; r < `SCR_DIFF_ROUNDS; r++) begin
      p = perm_bits_inv(block_t'(s), ByteW);
      s = p[ByteW-1:0];
      for (int n = 0; n < ByteW / 4; n++) begin
        s[4*n +: 4] = sbox4_inv(s[4*n +: 4]);
      end
    end
    return s;
  endfunction

  // Keystream goes first on writes so that on reads it can come last,
  // which hides the cipher's second half behind the SRAM access
  always_comb begin
    for (int b = 0; b < `SCR_BYTES; b++) begin
      wdata_scr_o[b*ByteW +: ByteW] =
          diffuse(wdata_i[b*ByteW +: ByteW] ^ keystream_i[b*ByteW +: ByteW]);
      rdata_plain_o[b*ByteW +: ByteW] =
          undiffuse(rdata_scr_i[b*ByteW +: ByteW]) ^ keystream_i[b*ByteW +: ByteW];
    end
  end

endmodule

/* scr_ram/init_filler.sv */
// Init request edge detect, seed LFSR, fill address counter, acknowledge and bus mux
`include "scr_ram_defs.svh"

module init_filler (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               init_req_i,
  input  scr_ram_pkg::lfsr_t init_seed_i,
  input  scr_ram_pkg::addr_t addr_i,
  input  scr_ram_pkg::data_t wdata_i,
  input  scr_ram_pkg::be_t   be_i,
  output logic               init_ack_o,
  output logic               init_active_o,
  output scr_ram_pkg::addr_t addr_o,
  output scr_ram_pkg::data_t wdata_o,
  output scr_ram_pkg::be_t   be_o
);

  import scr_ram_pkg::*;

  logic  init_req_q;
  logic  load_seed;
  lfsr_t lfsr_q;
  lfsr_t lfsr_next;
  addr_t cnt_q;

  // A fresh request loads the seed one cycle before the first fill write
  assign load_seed = init_req_i & ~init_req_q;

  // Fill runs from the cycle after the edge while the request stays up
  assign init_active_o = init_req_i & init_req_q;

  // Last address of the fill
  assign init_ack_o = init_active_o & (cnt_q == addr_t'(`SCR_DEPTH - 1));

  // Shift left and feed back the parity of the tapped bits
  assign lfsr_next = {lfsr_q[`SCR_LFSR_W-2:0], ^(lfsr_q & lfsr_t'(`SCR_LFSR_TAPS))};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_req_q <= 1'b0;
      lfsr_q     <= '0;
      cnt_q      <= '0;
    end else begin
      init_req_q <= init_req_i;
      if (load_seed) begin
        lfsr_q <= init_seed_i;
      end else if (init_active_o) begin
        lfsr_q <= lfsr_next;
      end
      // Restart from row zero on every new request and after the last row
      if (load_seed || init_ack_o) begin
        cnt_q <= '0;
      end else if (init_active_o) begin
        cnt_q <= cnt_q + addr_t'(1);
      end
    end
  end

  // Fill words are the LFSR state copied into every byte lane
  assign addr_o  = init_active_o ? cnt_q : addr_i;
  assign wdata_o = init_active_o ? {`SCR_BYTES{lfsr_q}} : wdata_i;
  assign be_o    = init_active_o ? '1 : be_i;

endmodule

/* scr_ram/keystream_gen.sv */
// Reduced-round PRINCE style block cipher with a halfway register for the CTR keystream
`include "scr_ram_defs.svh"

module keystream_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                valid_i,
  input  scr_ram_pkg::block_t block_i,
  input  scr_ram_pkg::key_t   key_i,
  output scr_ram_pkg::block_t keystream_o
);

  import scr_ram_pkg::*;

  localparam int Nibbles = `SCR_BLOCK_W / 4;

  // PRINCE round constants, the mirrored half adds alpha on top
  localparam block_t RC [5] = '{
    64'h0000000000000000,
    64'h13198a2e03707344,
    64'ha4093822299f31d0,
    64'h082efa98ec4e6c89,
    64'h452821e638d01377
  };
  localparam block_t Alpha = 64'hc0ac29b7c97c50dd;

  block_t k0;
  block_t k1;
  block_t k0_prime;
  block_t fwd;
  block_t half_q;
  block_t bwd;

  // Whitening key, core key and the derived output whitening key
  assign k0       = key_i[`SCR_KEY_W-1 -: `SCR_BLOCK_W];
  assign k1       = key_i[`SCR_BLOCK_W-1:0];
  assign k0_prime = {k0[0], k0[`SCR_BLOCK_W-1:1]} ^ (k0 >> (`SCR_BLOCK_W - 1));

  ////////////////////
  // Forward half
  ////////////////////

  always_comb begin
    fwd = block_i ^ k0;
    for (int r = 0; r < `SCR_CIPHER_HALF_ROUNDS; r++) begin
      fwd = fwd ^ k1 ^ RC[r];
      for (int n = 0; n < Nibbles; n++) begin
        fwd[4*n +: 4] = sbox4(fwd[4*n +: 4]);
      end
      fwd = perm_bits(fwd, `SCR_BLOCK_W);
    end
  end

  // Holds its value on idle cycles so a delayed write still sees its keystream
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q <= '0;
    end else if (valid_i) begin
      half_q <= fwd;
    end
  end

  ////////////////////
  // Mirrored half
  ////////////////////

  // The key is static, so it goes straight into the second half
  always_comb begin
    bwd = half_q;
    for (int r = `SCR_CIPHER_HALF_ROUNDS - 1; r >= 0; r--) begin
      bwd = perm_bits_inv(bwd, `SCR_BLOCK_W);
      for (int n = 0; n < Nibbles; n++) begin
        bwd[4*n +: 4] = sbox4_inv(bwd[4*n +: 4]);
      end
      bwd = bwd ^ k1 ^ RC[r] ^ Alpha;
    end
    keystream_o = bwd ^ k0_prime;
  end

endmodule

/* scr_ram/scr_ram_top.sv */
// Scrambled single-port RAM top with init filler, write hold, cipher, scramblers and macro
`include "scr_ram_defs.svh"

module scr_ram_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                key_valid_i,
  input  scr_ram_pkg::key_t   key_i,
  input  scr_ram_pkg::block_t nonce_i,
  input  scr_ram_pkg::lfsr_t  init_seed_i,
  input  logic                init_req_i,
  output logic                init_ack_o,
  input  logic                req_i,
  output logic                gnt_o,
  input  logic                write_i,
  input  scr_ram_pkg::addr_t  addr_i,
  input  scr_ram_pkg::data_t  wdata_i,
  input  scr_ram_pkg::be_t    be_i,
  output scr_ram_pkg::data_t  rdata_o,
  output logic                rvalid_o
);

  import scr_ram_pkg::*;

  // Nonce seen as address key plus counter nonce
  nonce_u nonce;
  assign nonce = nonce_i;

  // Bus side after the init mux
  logic   init_active;
  addr_t  bus_addr;
  data_t  bus_wdata;
  be_t    bus_be;

  // Cipher and data path
  block_t keystream;
  data_t  wdata_q;
  data_t  wdata_scr;
  data_t  rdata_scr;
  data_t  rdata_plain;

  // Macro side
  logic   macro_req;
  logic   macro_write;
  addr_t  macro_addr;
  addr_t  macro_addr_scr;
  be_t    macro_be;
  data_t  macro_wdata;

  init_filler u_init_filler (
    .clk_i,
    .rst_ni,
    .init_req_i,
    .init_seed_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .init_ack_o,
    .init_active_o (init_active),
    .addr_o        (bus_addr),
    .wdata_o       (bus_wdata),
    .be_o          (bus_be)
  );

  // The read strobe is already folded into the grant, so it stays inside
  write_hold u_write_hold (
    .clk_i,
    .rst_ni,
    .req_i,
    .write_i,
    .key_valid_i,
    .init_active_i (init_active),
    .addr_i        (bus_addr),
    .wdata_i       (bus_wdata),
    .be_i          (bus_be),
    .wdata_scr_i   (wdata_scr),
    .rdata_plain_i (rdata_plain),
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .read_en_o     (),
    .macro_req_o   (macro_req),
    .macro_write_o (macro_write),
    .macro_addr_o  (macro_addr),
    .macro_be_o    (macro_be),
    .macro_wdata_o (macro_wdata),
    .wdata_q_o     (wdata_q)
  );

  // Counter block is the data nonce joined to the plain row address
  // Init writes need a fresh keystream as well as granted accesses
  keystream_gen u_keystream_gen (
    .clk_i,
    .rst_ni,
    .valid_i     (gnt_o | init_active),
    .block_i     ({nonce.fields.data_nonce, bus_addr}),
    .key_i,
    .keystream_o (keystream)
  );

  data_scrambler u_data_scrambler (
    .wdata_i       (wdata_q),
    .rdata_scr_i   (rdata_scr),
    .keystream_i   (keystream[`SCR_DATA_W-1:0]),
    .wdata_scr_o   (wdata_scr),
    .rdata_plain_o (rdata_plain)
  );

  addr_scrambler u_addr_scrambler (
    .addr_i (macro_addr),
    .key_i  (nonce.fields.addr_key),
    .addr_o (macro_addr_scr)
  );

  sram_1p u_sram (
    .clk_i,
    .req_i   (macro_req),
    .write_i (macro_write),
    .addr_i  (macro_addr_scr),
    .wdata_i (macro_wdata),
    .be_i    (macro_be),
    .rdata_o (rdata_scr)
  );

endmodule

/* scr_ram/write_hold.sv */
// Grant and strobes, delayed and pending write registers, collision detect, forwarding mux
`include "scr_ram_defs.svh"

module write_hold (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               write_i,
  input  logic               key_valid_i,
  input  logic               init_active_i,
  input  scr_ram_pkg::addr_t addr_i,
  input  scr_ram_pkg::data_t wdata_i,
  input  scr_ram_pkg::be_t   be_i,
  input  scr_ram_pkg::data_t wdata_scr_i,
  input  scr_ram_pkg::data_t rdata_plain_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output scr_ram_pkg::data_t rdata_o,
  output logic               read_en_o,
  output logic               macro_req_o,
  output logic               macro_write_o,
  output scr_ram_pkg::addr_t macro_addr_o,
  output scr_ram_pkg::be_t   macro_be_o,
  output scr_ram_pkg::data_t macro_wdata_o,
  output scr_ram_pkg::data_t wdata_q_o
);

  import scr_ram_pkg::*;

  localparam int ByteW = `SCR_DATA_W / `SCR_BYTES;

  logic  read_en;
  logic  write_en_d;
  logic  write_en_q;
  logic  write_pending_q;
  logic  write_pending_d;
  logic  rw_collision;
  logic  addr_collision_d;
  logic  addr_collision_q;
  logic  rvalid_q;
  addr_t waddr_q;
  be_t   be_q;
  data_t wdata_q;
  data_t wdata_scr_q;

  ////////////////////
  // Strobes
  ////////////////////

  // No grant while the key is missing or the fill owns the port
  assign gnt_o      = req_i & key_valid_i & ~init_active_i;
  assign read_en    = gnt_o & ~write_i;
  assign read_en_o  = read_en;
  // Every fill cycle is a write as well
  assign write_en_d = (gnt_o & write_i) | init_active_i;

  // Writes go to the macro one cycle late, and only when no read wants it
  assign macro_req_o   = read_en | write_en_q | write_pending_q;
  assign macro_write_o = (write_en_q | write_pending_q) & ~read_en;
  assign rw_collision  = write_en_q & read_en;

  // A read takes the bus address, otherwise the held write address goes out
  assign macro_addr_o = read_en ? addr_i : waddr_q;
  assign macro_be_o   = be_q;

  // The cipher has moved on once a read cut in, so use the saved scrambled word
  assign macro_wdata_o = write_pending_q ? wdata_scr_q : wdata_scr_i;
  assign wdata_q_o     = wdata_q;

  // Read that hits the write still waiting for the macro
  assign addr_collision_d = read_en & (write_en_q | write_pending_q) & (addr_i == waddr_q);

  // Drop the flag once the write lands, raise it when a read pushes it back
  assign write_pending_d = macro_write_o ? 1'b0 :
                           rw_collision  ? 1'b1 :
                                           write_pending_q;

  ////////////////////
  // Forwarding mux
  ////////////////////

  assign rvalid_o = rvalid_q;

  always_comb begin
    rdata_o = '0;
    if (rvalid_q) begin
      rdata_o = rdata_plain_i;
    end
    // Bytes still in flight win over the stale memory word
    if (addr_collision_q) begin
      for (int b = 0; b < `SCR_BYTES; b++) begin
        if (be_q[b]) begin
          rdata_o[b*ByteW +: ByteW] = wdata_q[b*ByteW +: ByteW];
        end
      end
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_en_q       <= 1'b0;
      write_pending_q  <= 1'b0;
      addr_collision_q <= 1'b0;
      rvalid_q         <= 1'b0;
    end else begin
      write_en_q       <= write_en_d;
      write_pending_q  <= write_pending_d;
      addr_collision_q <= addr_collision_d;
      rvalid_q         <= read_en;
    end
  end

  // Write payload, only loaded by a new write or by a collision
  always_ff @(posedge clk_i) begin
    if (write_en_d) begin
      waddr_q <= addr_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
    if (rw_collision) begin
      wdata_scr_q <= wdata_scr_i;
    end
  end

endmodule

/* sources.f */
+incdir+common
common/scr_ram_pkg.sv
rtl/addr_scrambler.sv
rtl/sram_1p.sv
scr_ram/init_filler.sv
scr_ram/write_hold.sv
scr_ram/keystream_gen.sv
scr_ram/data_scrambler.sv
scr_ram/scr_ram_top.sv
bench/scr_ram_tb.sv
